/* design/alu_pkg.sv */
package alu_pkg;

   localparam int XLEN  = 32;
   localparam int TAG_W = 4;
   localparam int CNT_W = $clog2(XLEN);  // Bit counter inside a lane

   typedef logic [XLEN-1:0]  word_t;
   typedef logic [TAG_W-1:0] tag_t;     // Issue sequence number, wraps
   typedef logic [CNT_W-1:0] cnt_t;

   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLT  = 3'd5,
      OP_SLTU = 3'd6,
      OP_EQ   = 3'd7
   } alu_op_e;

   typedef struct packed {
      alu_op_e op;
      word_t   a;
      word_t   b;
      tag_t    tag;
   } alu_req_t;

   typedef struct packed {
      word_t result;
      tag_t  tag;
   } alu_rsp_t;

   // Shared by both four-phase ends
   typedef enum logic {
      HS_IDLE      = 1'b0,
      HS_WAIT_DROP = 1'b1
   } hs_state_e;

   typedef enum logic [1:0] {
      LANE_IDLE = 2'd0,
      LANE_RUN  = 2'd1,
      LANE_HOLD = 2'd2
   } lane_state_e;

   // Compare ops return a flag in bit 0
   function automatic logic op_is_cmp(input alu_op_e op);
      logic is_cmp;
      case (op)
         OP_SLT, OP_SLTU, OP_EQ: is_cmp = 1'b1;
         default:                is_cmp = 1'b0;
      endcase
      return is_cmp;
   endfunction

endpackage

/* design/op_dispatch.sv */
`timescale 1ns/1ps

module op_dispatch #(
   parameter int NUM_LANES = 4
) (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_req_valid,
   input  alu_pkg::alu_req_t    i_req,
   output logic                 o_req_ack,
   input  logic [NUM_LANES-1:0] i_busy,
   output logic [NUM_LANES-1:0] o_start,
   output alu_pkg::alu_req_t    o_lane_req
);

   import alu_pkg::*;

   localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   hs_state_e        state;
   logic [PTR_W-1:0] lane_ptr;
   logic [PTR_W-1:0] next_ptr;
   logic             valid_q;
   logic             issue;

   // Valid must be seen on two consecutive edges before a lane is started
   assign issue = (state == HS_IDLE) && valid_q && i_req_valid && !i_busy[lane_ptr];

   assign next_ptr = (lane_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state     <= HS_IDLE;
         lane_ptr  <= '0;
         valid_q   <= 1'b0;
         o_req_ack <= 1'b0;
         o_start   <= '0;
      end else begin
         o_start <= '0;  // Start is a single-cycle pulse
         valid_q <= i_req_valid;
         case (state)
            HS_IDLE: begin
               if (issue) begin
                  o_start[lane_ptr] <= 1'b1;
                  o_req_ack         <= 1'b1;
                  lane_ptr          <= next_ptr;
                  state             <= HS_WAIT_DROP;
               end
            end
            HS_WAIT_DROP: begin
               if (!i_req_valid) begin  // Source released, close the handshake
                  o_req_ack <= 1'b0;
                  state     <= HS_IDLE;
               end
            end
            default: begin
               state <= HS_IDLE;
            end
         endcase
      end
   end

   // Shared request bus, held until the next issue
   always_ff @(posedge clk) begin
      if (issue) begin
         o_lane_req <= i_req;
      end
   end

   a_start_onehot: assert property (
      @(posedge clk) disable iff (i_rst)
      $onehot0(o_start)
   ) else $error("op_dispatch: more than one lane started in one cycle");

   a_ack_needs_valid: assert property (
      @(posedge clk) disable iff (i_rst)
      $rose(o_req_ack) |-> $past(i_req_valid)
   ) else $error("op_dispatch: o_req_ack rose without i_req_valid");

endmodule

/* design/serial_alu_lane.sv */
`timescale 1ns/1ps

module serial_alu_lane (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_start,
   input  alu_pkg::alu_req_t i_req,
   output logic              o_busy,
   output logic              o_done,
   output alu_pkg::alu_rsp_t o_rsp,
   input  logic              i_take
);

   import alu_pkg::*;

   // Xor, xnor, or, and; indexed by {sel, a, b}
   localparam logic [15:0] BOOL_LUT = 16'h8E96;

   lane_state_e state;
   cnt_t        bit_cnt;
   alu_op_e     op_q;
   tag_t        tag_q;
   word_t       a_sr;
   word_t       b_sr;
   word_t       res_sr;
   logic        carry_q;
   logic        eq_q;
   logic        lt_q;

   logic        a_bit;
   logic        b_bit;
   logic        b_add;
   logic        last_bit;
   logic        sum_bit;
   logic        carry_next;
   logic [1:0]  bool_sel;
   logic        bool_bit;
   logic        eq_next;
   logic        sign_cmp;
   logic        lt_next;
   logic        cmp_flag;
   logic        res_bit;

   assign a_bit    = a_sr[0];
   assign b_bit    = b_sr[0];
   assign last_bit = (bit_cnt == cnt_t'(XLEN - 1));

   // Sub runs as a + ~b with the carry preset to one at load
   assign b_add      = (op_q == OP_SUB) ? ~b_bit : b_bit;
   assign sum_bit    = a_bit ^ b_add ^ carry_q;
   assign carry_next = (a_bit & b_add) | (carry_q & (a_bit ^ b_add));

   always_comb begin
      case (op_q)
         OP_AND:  bool_sel = 2'b11;
         OP_OR:   bool_sel = 2'b10;
         default: bool_sel = 2'b00;
      endcase
   end

   assign bool_bit = BOOL_LUT[{bool_sel, a_bit, b_bit}];

   assign eq_next  = eq_q & (a_bit == b_bit);
   assign sign_cmp = last_bit & (op_q == OP_SLT);  // MSB decides by sign
   assign lt_next  = (a_bit == b_bit) ? lt_q : (sign_cmp ? a_bit : b_bit);
   assign cmp_flag = (op_q == OP_EQ) ? eq_next : lt_next;

   always_comb begin
      case (op_q)
         OP_ADD, OP_SUB:        res_bit = sum_bit;
         OP_AND, OP_OR, OP_XOR: res_bit = bool_bit;
         default:               res_bit = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state   <= LANE_IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            LANE_IDLE: begin
               if (i_start) begin
                  state   <= LANE_RUN;
                  bit_cnt <= '0;
               end
            end
            LANE_RUN: begin
               bit_cnt <= bit_cnt + cnt_t'(1);
               if (last_bit) begin
                  state <= LANE_HOLD;
               end
            end
            LANE_HOLD: begin
               if (i_take) begin
                  state <= LANE_IDLE;
               end
            end
            default: begin
               state <= LANE_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_start && (state == LANE_IDLE)) begin
         a_sr    <= i_req.a;
         b_sr    <= i_req.b;
         op_q    <= i_req.op;
         tag_q   <= i_req.tag;
         carry_q <= (i_req.op == OP_SUB);
         eq_q    <= 1'b1;
         lt_q    <= 1'b0;
      end else if (state == LANE_RUN) begin
         a_sr    <= a_sr >> 1;
         b_sr    <= b_sr >> 1;
         carry_q <= carry_next;
         eq_q    <= eq_next;
         lt_q    <= lt_next;
         if (last_bit && op_is_cmp(op_q)) begin
            res_sr <= word_t'(cmp_flag);  // Flag zero-extended into bit 0
         end else begin
            res_sr <= {res_bit, res_sr[XLEN-1:1]};  // LSB first, fills from the top
         end
      end
   end

   assign o_busy = (state != LANE_IDLE);
   assign o_done = (state == LANE_HOLD);
   assign o_rsp  = '{result: res_sr, tag: tag_q};

   a_start_when_idle: assert property (
      @(posedge clk) disable iff (i_rst)
      i_start |-> !o_busy
   ) else $error("serial_alu_lane: start while busy");

endmodule

/* design/result_collect.sv */
`timescale 1ns/1ps

module result_collect #(
   parameter int NUM_LANES = 4
) (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic [NUM_LANES-1:0] i_done,
   input  alu_pkg::alu_rsp_t    i_lane_rsp [NUM_LANES],
   output logic [NUM_LANES-1:0] o_take,
   output logic                 o_rsp_valid,
   output alu_pkg::alu_rsp_t    o_rsp,
   input  logic                 i_rsp_ack
);

   import alu_pkg::*;

   localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   hs_state_e        state;
   logic [PTR_W-1:0] drain_ptr;
   logic [PTR_W-1:0] next_ptr;
   logic             load;

   assign load     = (state == HS_IDLE) && i_done[drain_ptr];
   assign next_ptr = (drain_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : drain_ptr + 1'b1;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state       <= HS_IDLE;
         drain_ptr   <= '0;
         o_rsp_valid <= 1'b0;
         o_take      <= '0;
      end else begin
         o_take <= '0;
         case (state)
            HS_IDLE: begin
               if (load) begin
                  o_take[drain_ptr] <= 1'b1;  // Frees the lane
                  o_rsp_valid       <= 1'b1;
                  state             <= HS_WAIT_DROP;
               end
            end
            HS_WAIT_DROP: begin
               // Valid high waits for ack, valid low waits for ack release
               if (o_rsp_valid) begin
                  if (i_rsp_ack) begin
                     o_rsp_valid <= 1'b0;
                  end
               end else if (!i_rsp_ack) begin
                  drain_ptr <= next_ptr;
                  state     <= HS_IDLE;
               end
            end
            default: begin
               state <= HS_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         o_rsp <= i_lane_rsp[drain_ptr];
      end
   end

   a_rsp_stable: assert property (
      @(posedge clk) disable iff (i_rst)
      (o_rsp_valid && !i_rsp_ack) |=> $stable(o_rsp)
   ) else $error("result_collect: o_rsp changed while waiting for ack");

endmodule

/* design/serial_alu_array.sv */
`timescale 1ns/1ps

module serial_alu_array #(
   parameter int NUM_LANES = 4
) (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_req_valid,
   input  alu_pkg::alu_req_t i_req,
   output logic              o_req_ack,
   output logic              o_rsp_valid,
   output alu_pkg::alu_rsp_t o_rsp,
   input  logic              i_rsp_ack
);

   import alu_pkg::*;

   logic [NUM_LANES-1:0] lane_busy;
   logic [NUM_LANES-1:0] lane_start;
   logic [NUM_LANES-1:0] lane_done;
   logic [NUM_LANES-1:0] lane_take;
   alu_req_t             lane_req;   // Shared by every lane, qualified by start
   alu_rsp_t             lane_rsp [NUM_LANES];

   op_dispatch #(
      .NUM_LANES (NUM_LANES)
   ) op_dispatch_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .o_req_ack   (o_req_ack),
      .i_busy      (lane_busy),
      .o_start     (lane_start),
      .o_lane_req  (lane_req)
   );

   for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
      serial_alu_lane serial_alu_lane_inst (
         .clk     (clk),
         .i_rst   (i_rst),
         .i_start (lane_start[k]),
         .i_req   (lane_req),
         .o_busy  (lane_busy[k]),
         .o_done  (lane_done[k]),
         .o_rsp   (lane_rsp[k]),
         .i_take  (lane_take[k])
      );
   end

   result_collect #(
      .NUM_LANES (NUM_LANES)
   ) result_collect_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_done      (lane_done),
      .i_lane_rsp  (lane_rsp),
      .o_take      (lane_take),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .i_rsp_ack   (i_rsp_ack)
   );

endmodule

/* tb/alu_checker.sv */
`timescale 1ns/1ps

module alu_checker (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_req_ack,
   input  alu_pkg::alu_req_t i_req,
   input  logic              i_file_exp,
   input  alu_pkg::word_t    i_file_result,
   input  logic              i_rsp_valid,
   input  alu_pkg::alu_rsp_t i_rsp,
   output int                o_value_errors,
   output int                o_other_errors,
   output int                o_req_count,
   output int                o_rsp_count
);

   import alu_pkg::*;

   alu_rsp_t exp_q [$];          // Outstanding requests in issue order
   logic     ack_q;
   logic     valid_q;
   int       value_errors = 0;
   int       other_errors = 0;
   int       req_count    = 0;
   int       rsp_count    = 0;

   // Reference results for the random requests
   function automatic word_t model_result(input alu_op_e op, input word_t a, input word_t b);
      word_t r;
      case (op)
         OP_ADD:  r = a + b;
         OP_SUB:  r = a - b;
         OP_AND:  r = a & b;
         OP_OR:   r = a | b;
         OP_XOR:  r = a ^ b;
         OP_SLT:  r = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
         OP_SLTU: r = (a < b) ? word_t'(1) : word_t'(0);
         default: r = (a == b) ? word_t'(1) : word_t'(0);
      endcase
      return r;
   endfunction

   always @(posedge clk) begin
      alu_rsp_t want;
      if (i_rst) begin
         ack_q   = 1'b0;
         valid_q = 1'b0;
         exp_q.delete();
      end else begin
         if (i_req_ack && !ack_q) begin  // Request handshake completed
            want.tag    = i_req.tag;
            want.result = i_file_exp ? i_file_result : model_result(i_req.op, i_req.a, i_req.b);
            exp_q.push_back(want);
            req_count++;
         end
         if (i_rsp_valid && !valid_q) begin
            rsp_count++;
            if (exp_q.size() == 0) begin
               $display("response at %0t arrived with no request outstanding", $time);
               other_errors++;
            end else begin
               want = exp_q.pop_front();
               if (i_rsp.result !== want.result) begin
                  $display("error at %0t: o_rsp.result got %h expected %h",
                           $time, i_rsp.result, want.result);
                  value_errors++;
               end
               if (i_rsp.tag !== want.tag) begin
                  $display("error at %0t: o_rsp.tag got %h expected %h",
                           $time, i_rsp.tag, want.tag);
                  value_errors++;
               end
            end
         end
         ack_q   = i_req_ack;
         valid_q = i_rsp_valid;
      end
   end

   assign o_value_errors = value_errors;
   assign o_other_errors = other_errors;
   assign o_req_count    = req_count;
   assign o_rsp_count    = rsp_count;

endmodule

/* tb/tb_serial_alu_array.sv */
`timescale 1ns/1ps

module tb_serial_alu_array;

   import alu_pkg::*;

   localparam int          NUM_LANES = 4;
   localparam int          TIMEOUT   = 2000;
   localparam logic [31:0] SEED      = 32'hf4111d74;

   logic        clk;
   logic        i_rst;
   logic        i_req_valid;
   alu_req_t    i_req;
   logic        o_req_ack;
   logic        o_rsp_valid;
   alu_rsp_t    o_rsp;
   logic        i_rsp_ack;
   logic        file_exp;     // Expected value for this request comes from the file
   word_t       file_result;
   logic        run_done;
   logic        aborted;
   string       abort_why;
   tag_t        next_tag;
   int          sent;
   int          tb_errors;
   int          value_errors;
   int          other_errors;
   int          req_seen;
   int          rsp_seen;
   logic [31:0] req_seed;
   logic [31:0] ack_seed;

   serial_alu_array #(
      .NUM_LANES (NUM_LANES)
   ) serial_alu_array_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .o_req_ack   (o_req_ack),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .i_rsp_ack   (i_rsp_ack)
   );

   alu_checker alu_checker_inst (
      .clk            (clk),
      .i_rst          (i_rst),
      .i_req_ack      (o_req_ack),
      .i_req          (i_req),
      .i_file_exp     (file_exp),
      .i_file_result  (file_result),
      .i_rsp_valid    (o_rsp_valid),
      .i_rsp          (o_rsp),
      .o_value_errors (value_errors),
      .o_other_errors (other_errors),
      .o_req_count    (req_seen),
      .o_rsp_count    (rsp_seen)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic print_counts();
      $display("errors: %0d value, %0d other; requests %0d, responses %0d",
               value_errors, other_errors + tb_errors, req_seen, rsp_seen);
   endtask

   // Parks the calling process, the watchdog ends the run
   task automatic abort_run(input string why);
      abort_why = why;
      aborted   = 1'b1;
      forever @(negedge clk);
   endtask

   // Full four-phase cycle on the request port
   task automatic send_request(input alu_op_e op, input word_t a, input word_t b,
                               input logic from_file, input word_t result);
      int cycles;
      @(negedge clk);
      i_req.op    = op;
      i_req.a     = a;
      i_req.b     = b;
      i_req.tag   = next_tag;
      file_exp    = from_file;
      file_result = result;
      i_req_valid = 1'b1;
      cycles = 0;
      while (!o_req_ack) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("o_req_ack did not rise for a pending request");
      end
      i_req_valid = 1'b0;
      cycles = 0;
      while (o_req_ack) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("o_req_ack did not fall after i_req_valid dropped");
      end
      next_tag = next_tag + tag_t'(1);
      sent++;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin : watchdog
      aborted   = 1'b0;
      abort_why = "";
      wait (aborted);
      $display("run aborted: %s", abort_why);
      print_counts();
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : driver
      int          fd;
      int          file_lines;
      int          cycles;
      string       line;
      logic [31:0] op_raw;
      word_t       a;
      word_t       b;
      word_t       want;
      alu_op_e     op;
      i_rst       = 1'b1;
      i_req_valid = 1'b0;
      i_req       = '0;
      file_exp    = 1'b0;
      file_result = '0;
      run_done    = 1'b0;
      next_tag    = '0;
      sent        = 0;
      tb_errors   = 0;
      file_lines  = 0;
      req_seed    = SEED;
      repeat (3) @(negedge clk);
      i_rst = 1'b0;

      fd = $fopen("tb/alu_input.txt", "r");
      if (fd == 0) abort_run("cannot open tb/alu_input.txt");
      while (!$feof(fd)) begin
         if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h %h", op_raw, a, b, want) == 4) begin
            op = alu_op_e'(op_raw[2:0]);
            send_request(op, a, b, 1'b1, want);
            file_lines++;
         end
      end
      $fclose(fd);
      if (file_lines == 0) abort_run("no stimulus lines found in tb/alu_input.txt");

      for (int i = 0; i < 40; i++) begin
         req_seed = lcg_next(req_seed);
         op       = alu_op_e'(req_seed[30:28]);
         req_seed = lcg_next(req_seed);
         a        = req_seed;
         req_seed = lcg_next(req_seed);
         b        = req_seed;
         if (op == OP_EQ && a[20]) b = a;  // Give eq a fair share of matches
         send_request(op, a, b, 1'b0, '0);
      end

      cycles = 0;
      while (rsp_seen != sent) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("not every request got a response");
      end
      repeat (40) @(negedge clk);  // Room for a stray extra response to show up
      if (rsp_seen != sent || req_seen != sent) begin
         $display("count mismatch: %0d requests sent, %0d acknowledged, %0d responses",
                  sent, req_seen, rsp_seen);
         tb_errors++;
      end
      run_done = 1'b1;
      print_counts();
      if (value_errors + other_errors + tb_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Response side with a random 0 to 5 cycle delay before each ack
   initial begin : acknowledger
      int idle;
      int delay;
      int cycles;
      i_rsp_ack = 1'b0;
      ack_seed  = SEED;
      idle      = 0;
      while (!run_done) begin
         @(negedge clk);
         if (o_rsp_valid === 1'b1) begin
            idle     = 0;
            ack_seed = lcg_next(ack_seed);
            delay    = int'(ack_seed[23:16]) % 6;
            repeat (delay) @(negedge clk);
            i_rsp_ack = 1'b1;
            cycles = 0;
            while (o_rsp_valid) begin
               @(negedge clk);
               cycles++;
               if (cycles > TIMEOUT) abort_run("o_rsp_valid did not fall after i_rsp_ack");
            end
            i_rsp_ack = 1'b0;
         end else begin
            idle++;
            if (idle > TIMEOUT) abort_run("no response arrived while waiting for o_rsp_valid");
         end
      end
   end

endmodule

/* tb/alu_input.txt */
# Each line holds op code, operand a, operand b and expected result in hex
# Op codes 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sltu 7 eq
0 ffffffff 00000001 00000000
0 7fffffff 00000001 80000000
0 12345678 87654321 99999999
1 00000005 00000003 00000002
1 00000003 00000005 fffffffe
1 00000000 00000001 ffffffff
1 80000000 00000001 7fffffff
2 f0f0a5a5 ff00ff00 f000a500
3 f0f0a5a5 0f0f0000 ffffa5a5
4 f0f0a5a5 ff00ff00 0ff05aa5
5 ffffffff 00000001 00000001
6 ffffffff 00000001 00000000
5 00000001 80000000 00000000
6 00000001 80000000 00000001
5 80000000 7fffffff 00000001
5 fffffffe ffffffff 00000001
5 00000007 00000007 00000000
7 12345678 12345678 00000001
7 92345678 12345678 00000000
7 12345679 12345678 00000000

/* build.f */
design/alu_pkg.sv
design/op_dispatch.sv
design/serial_alu_lane.sv
design/result_collect.sv
design/serial_alu_array.sv
tb/alu_checker.sv
tb/tb_serial_alu_array.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the serial ALU array testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module tb_serial_alu_array \
   -Mdir obj_dir \
   -f build.f

./obj_dir/Vtb_serial_alu_array | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
